/* coeff.hex */
// tap 0 to 63, one signed 24-bit coefficient per line in two's complement hex
00154D
000885
FFF62B
FFE22E
FFD416
FFD4BF
FFEBAF
001893
004EA5
00754F
007209
0033C6
FFC2B9
FF4299
FEEDBA
FEFD76
FF8D50
0084B6
019168
023CCB
021719
00EC42
FEEDBB
FCB9CB
FB3C0E
FB66F9
FDDDC2
02AB8A
0927E7
1010B5
15DCC6
192ADA
192ADA
15DCC6
1010B5
0927E7
02AB8A
FDDDC2
FB66F9
FB3C0E
FCB9CB
FEEDBB
00EC42
021719
023CCB
019168
0084B6
FF8D50
FEFD76
FEEDBA
FF4299
FFC2B9
0033C6
007209
00754F
004EA5
001893
FFEBAF
FFD4BF
FFD416
FFE22E
FFF62B
000885
00154D

/* sim.f */
fir_pkg.sv
fir_coeff_rom.sv
fir_sequencer.sv
fir_sample_ring.sv
fir_mac.sv
fir_round.sv
fir_filter.sv
fir_filter_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the fir filter testbench with verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module fir_filter_tb -f sim.f -o fir_filter_sim

./obj_dir/fir_filter_sim | tee sim.log

if grep -qx "TEST PASS" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

/* fir_filter_tb.sv */
/*
  fir filter testbench
  a table of samples applied in a loop; a reference history
  and the rounding rule give the expected out_data
*/
`default_nettype none

module fir_filter_tb;

  import fir_pkg::*;

  localparam int max_rows = 400;
  localparam int limit    = 200;  // cycles allowed for any wait
  localparam int k_val    = 0;    // sample from the value column
  localparam int k_rnd    = 1;    // 24 bits from the lfsr
  localparam int k_hi     = 2;    // full scale, same sign as coeff[value]
  localparam int k_lo     = 3;    // full scale, opposite sign

  logic                          clock = 1'b0;
  logic                          rst;
  logic                          start;
  logic signed [sample_bits-1:0] in_data;
  logic signed [out_bits-1:0]    out_data;
  logic                          out_strobe;
  logic                          busy;

  // stimulus table, one entry per start pulse
  int row_test  [max_rows];
  int row_kind  [max_rows];
  int row_value [max_rows];
  bit row_busy  [max_rows];  // second start while busy
  bit row_reset [max_rows];  // reset before the row
  int num_rows;

  logic signed [sample_bits-1:0] coeff_ref [num_taps];
  logic signed [sample_bits-1:0] history   [num_taps];  // [0] is x[n]
  logic [31:0]                   lfsr;
  int                            pass_count;
  int                            fail_count;
  int                            test_errors;
  bit                            timed_out;

  fir_filter i_fir_filter (
    .clock      (clock),
    .rst        (rst),
    .start      (start),
    .in_data    (in_data),
    .out_data   (out_data),
    .out_strobe (out_strobe),
    .busy       (busy)
  );

  always #4 clock = ~clock;  // period 8

  task automatic add_row(input int test, input int kind, input int value,
                         input bit second_start, input bit reset_first);
    row_test[num_rows]  = test;
    row_kind[num_rows]  = kind;
    row_value[num_rows] = value;
    row_busy[num_rows]  = second_start;
    row_reset[num_rows] = reset_first;
    num_rows++;
  endtask

  // galois lfsr x^32 + x^22 + x^2 + x + 1, one step per bit taken
  function automatic logic [sample_bits-1:0] random_sample();
    int                     i;
    logic [sample_bits-1:0] v;
    v = '0;
    for (i = 0; i < sample_bits; i++)
    begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      v    = {v[sample_bits-2:0], lfsr[0]};
    end
    return v;
  endfunction

  // y = sum coeff[k] * x[n-k], then floor(y / 2^24 + 1/2) clamped to 32 bits
  function automatic logic signed [out_bits-1:0] model_out();
    longint y;
    int     k;
    y = 0;
    for (k = 0; k < num_taps; k++)
      y += longint'(coeff_ref[k]) * longint'(history[k]);
    y = (y + (longint'(1) << 23)) >>> 24;
    if (y > 64'sd2147483647)
      return 32'sh7fff_ffff;
    else if (y < -64'sd2147483648)
      return 32'sh8000_0000;
    else
      return out_bits'(y);
  endfunction

  initial
  begin
    int                            r;
    int                            k;
    int                            cycles;
    int                            cur_test;
    logic signed [sample_bits-1:0] s;
    logic signed [out_bits-1:0]    want;
    bit                            quiet;
    rst         = 1'b1;
    start       = 1'b0;
    in_data     = '0;
    lfsr        = 32'h77bc_bdcb;
    pass_count  = 0;
    fail_count  = 0;
    test_errors = 0;
    timed_out   = 1'b0;
    num_rows    = 0;
    $readmemh("coeff.hex", coeff_ref);
    for (k = 0; k < num_taps; k++)
      history[k] = '0;

    // --------------------------------------------------
    // stimulus table
    // --------------------------------------------------
    add_row(1, k_val, 'h40_0000, 1'b0, 1'b1);  // impulse reads out coeff / 4
    for (k = 1; k < num_taps; k++)
      add_row(1, k_val, 0, 1'b0, 1'b0);
    add_row(2, k_val, -'h40_0000, 1'b0, 1'b1);  // negative impulse, ties go up
    for (k = 1; k < num_taps; k++)
      add_row(2, k_val, 0, 1'b0, 1'b0);
    for (k = 0; k < 40; k++)
      add_row(2, k_val, 'h2a_5c3d, 1'b0, 1'b0);  // step
    for (k = 0; k < num_taps; k++)
      add_row(2, k_rnd, 0, 1'b0, 1'b0);
    for (k = 0; k < num_taps; k++)
      add_row(3, k_hi, num_taps - 1 - k, 1'b0, k == 0);  // peak on the last row
    for (k = 0; k < num_taps; k++)
      add_row(3, k_lo, num_taps - 1 - k, 1'b0, 1'b0);
    for (k = 0; k < 6; k++)
      add_row(4, k_rnd, 0, k < 4, 1'b0);  // last two show the dropped samples are gone
    for (k = 0; k < 4; k++)
      add_row(5, k_rnd, 0, 1'b0, k == 2);  // reset in mid-stream

    repeat (10) @(posedge clock);
    rst <= 1'b0;
    cur_test = row_test[0];

    for (r = 0; r < num_rows && !timed_out; r++)
    begin
      if (row_test[r] != cur_test)
      begin
        $display("test %0d done, %0d errors", cur_test, test_errors);
        test_errors = 0;
        cur_test    = row_test[r];
      end
      if (row_reset[r])
      begin
        @(posedge clock);
        rst <= 1'b1;
        repeat (3) @(posedge clock);
        rst <= 1'b0;
        for (k = 0; k < num_taps; k++)
          history[k] = '0;  // ring is cleared with the reset
        @(negedge clock);
        if (out_data !== '0)
        begin
          $display("error out_data after reset test %0d row %0d expected %h actual %h",
                   row_test[r], r, {out_bits{1'b0}}, out_data);
          fail_count++;
          test_errors++;
        end
        else
          pass_count++;
      end
      case (row_kind[r])
        k_val:   s = row_value[r][sample_bits-1:0];
        k_rnd:   s = random_sample();
        default: s = ((coeff_ref[row_value[r]] < 0) == (row_kind[r] == k_lo)) ?
                     24'sh7f_ffff : 24'sh80_0000;
      endcase

      // engine has to be idle or the start is dropped
      cycles = 0;
      @(negedge clock);
      while (busy && cycles < limit)
      begin
        cycles++;
        @(negedge clock);
      end
      if (busy)
      begin
        $display("engine stayed busy for %0d cycles in test %0d", limit, row_test[r]);
        timed_out = 1'b1;
      end
      else
      begin
        for (k = num_taps - 1; k > 0; k--)
          history[k] = history[k - 1];
        history[0] = s;
        want       = model_out();
        @(posedge clock);
        start   <= 1'b1;
        in_data <= s;
        @(posedge clock);  // accepting edge
        start   <= 1'b0;
        in_data <= ~s;     // only the start edge may sample in_data
        cycles  = 0;
        if (row_busy[r])
        begin
          @(posedge clock);
          start   <= 1'b1;  // seen in seq_accumulate, dropped
          in_data <= 24'h5a_5a5a;
          @(posedge clock);
          start   <= 1'b0;
          cycles  = 2;
        end
        @(negedge clock);
        // busy rises on the accepting edge
        if (busy !== 1'b1)
        begin
          $display("error busy test %0d row %0d expected %h actual %h",
                   row_test[r], r, 1'b1, busy);
          fail_count++;
          test_errors++;
        end
        else
          pass_count++;
        while (!out_strobe && cycles < limit)
        begin
          cycles++;
          @(negedge clock);
        end
        if (!out_strobe)
        begin
          $display("no out_strobe within %0d cycles in test %0d row %0d", limit, row_test[r], r);
          timed_out = 1'b1;
        end
        else
        begin
          if (cycles != num_taps + 6)
          begin
            $display("out_strobe came %0d cycles after start, expected %0d", cycles, num_taps + 6);
            fail_count++;
            test_errors++;
          end
          else
            pass_count++;
          if (out_data !== want)
          begin
            $display("error out_data test %0d row %0d expected %h actual %h",
                     row_test[r], r, want, out_data);
            fail_count++;
            test_errors++;
          end
          else
            pass_count++;
          // busy falls on the edge that raises out_strobe
          if (busy !== 1'b0)
          begin
            $display("error busy test %0d row %0d expected %h actual %h",
                     row_test[r], r, 1'b0, busy);
            fail_count++;
            test_errors++;
          end
          else
            pass_count++;
          // one cycle pulse; a dropped start brings no second result
          quiet = 1'b1;
          repeat (row_busy[r] ? num_taps + 8 : 1)
          begin
            @(negedge clock);
            if (out_strobe)
              quiet = 1'b0;
          end
          if (!quiet)
          begin
            $display("out_strobe pulsed again without an accepted start in test %0d", row_test[r]);
            fail_count++;
            test_errors++;
          end
          else
            pass_count++;
        end
      end
    end

    $display("test %0d done, %0d errors", cur_test, test_errors);
    $display("%0d checks passed, %0d checks failed", pass_count, fail_count);
    if (fail_count == 0 && !timed_out)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* fir_filter.sv */
/*
  fir filter engine top
  one start pulse in, one rounded result out num_taps+6
  cycles later; sequencer, history, ROM, MAC and rounding
*/
`default_nettype none

module fir_filter (
  input  logic                                   clock,
  input  logic                                   rst,
  input  logic                                   start,
  input  logic signed [fir_pkg::sample_bits-1:0] in_data,
  output logic signed [fir_pkg::out_bits-1:0]    out_data,
  output logic                                   out_strobe,
  output logic                                   busy
);

  import fir_pkg::*;

  logic                          ring_write;
  logic [tap_bits-1:0]           tap_index;
  mac_op_t                       mac_op;
  logic                          round_go;
  logic signed [sample_bits-1:0] sample;   // from the history
  logic signed [sample_bits-1:0] coeff;    // from the ROM
  logic signed [acc_bits-1:0]    acc_out;

  // --------------------------------------------------
  // decode
  // --------------------------------------------------
  fir_sequencer i_fir_sequencer (
    .clock      (clock),
    .rst        (rst),
    .start      (start),
    .busy       (busy),
    .ring_write (ring_write),
    .tap_index  (tap_index),
    .mac_op     (mac_op),
    .round_go   (round_go)
  );

  // --------------------------------------------------
  // execute
  // --------------------------------------------------
  fir_sample_ring i_fir_sample_ring (
    .clock     (clock),
    .rst       (rst),
    .write     (ring_write),
    .in_data   (in_data),
    .tap_index (tap_index),
    .sample    (sample)
  );

  fir_coeff_rom i_fir_coeff_rom (
    .clock     (clock),
    .tap_index (tap_index),
    .coeff     (coeff)
  );

  fir_mac i_fir_mac (
    .clock   (clock),
    .rst     (rst),
    .mac_op  (mac_op),
    .sample  (sample),
    .coeff   (coeff),
    .acc_out (acc_out)
  );

  // result
  fir_round i_fir_round (
    .clock      (clock),
    .rst        (rst),
    .round_go   (round_go),
    .acc_in     (acc_out),
    .out_data   (out_data),
    .out_strobe (out_strobe)
  );

endmodule

`default_nettype wire

/* fir_round.sv */
/*
  fir result stage
  rounds the accumulator half up at the binary point,
  saturates to 32 bits and registers it with out_strobe
*/
`default_nettype none

module fir_round (
  input  logic                                clock,
  input  logic                                rst,
  input  logic                                round_go,
  input  logic signed [fir_pkg::acc_bits-1:0] acc_in,
  output logic signed [fir_pkg::out_bits-1:0] out_data,
  output logic                                out_strobe
);

  import fir_pkg::*;

  logic [acc_bits:0]             biased;  // one guard bit for the +1/2
  logic [out_bits:0]             quot;    // 33 bit rounded value
  logic signed [out_bits-1:0]    sat;

  // add half an LSB of the output, then drop the fraction
  assign biased = {acc_in[acc_bits-1], acc_in}
                + ((acc_bits + 1)'(1) << (acc_bits - out_bits - 1));
  assign quot   = biased[acc_bits:acc_bits-out_bits];

  // top two bits disagree -> does not fit in out_bits
  always_comb
  begin
    if (quot[out_bits] == quot[out_bits-1])
      sat = quot[out_bits-1:0];
    else if (!quot[out_bits])
      sat = {1'b0, {(out_bits - 1){1'b1}}};  // clamp high
    else
      sat = {1'b1, {(out_bits - 1){1'b0}}};  // clamp low
  end

  always_ff @(posedge clock)
  begin
    if (rst)
    begin
      out_data   <= '0;
      out_strobe <= 1'b0;
    end
    else
    begin
      out_strobe <= round_go;  // one pulse per result
      if (round_go)
        out_data <= sat;       // held between results
    end
  end

endmodule

`default_nettype wire

/* fir_mac.sv */
/*
  fir multiply-accumulate
  three stages: operand register, signed product, accumulate;
  the opcode rides along so runs can follow back to back
*/
`default_nettype none

module fir_mac (
  input  logic                                   clock,
  input  logic                                   rst,
  input  fir_pkg::mac_op_t                       mac_op,
  input  logic signed [fir_pkg::sample_bits-1:0] sample,
  input  logic signed [fir_pkg::sample_bits-1:0] coeff,
  output logic signed [fir_pkg::acc_bits-1:0]    acc_out
);

  import fir_pkg::*;

  mac_op_t                          op_s1;    // opcode at stage 1
  mac_op_t                          op_s2;    // opcode at stage 2
  logic signed [sample_bits-1:0]    a_s1;     // sample operand
  logic signed [sample_bits-1:0]    b_s1;     // coefficient operand
  logic signed [2*sample_bits-1:0]  prod_s2;  // full product

  // --------------------------------------------------
  // opcode pipe
  // --------------------------------------------------
  always_ff @(posedge clock)
  begin
    if (rst)
    begin
      op_s1 <= mac_nop;
      op_s2 <= mac_nop;
    end
    else
    begin
      op_s1 <= mac_op;
      op_s2 <= op_s1;
    end
  end

  // --------------------------------------------------
  // datapath
  // --------------------------------------------------
  always_ff @(posedge clock)
  begin
    a_s1    <= sample;       // stage 1
    b_s1    <= coeff;
    prod_s2 <= a_s1 * b_s1;  // stage 2, 48 bit signed

    // stage 3
    case (op_s2)
      mac_first: acc_out <= acc_bits'(prod_s2);            // new run
      mac_next:  acc_out <= acc_out + acc_bits'(prod_s2);
      default:   acc_out <= acc_out;                       // hold for rounding
    endcase
  end

  // every run opens with mac_first, so next never follows an idle slot
  a_next_after_op: assert property (@(posedge clock) disable iff (rst)
    (op_s2 == mac_next) |-> ($past(op_s2) != mac_nop));

endmodule

`default_nettype wire

/* fir_sample_ring.sv */
/*
  fir sample history
  circular register file of the last num_taps samples,
  cleared by reset; tap 0 reads back the newest sample
*/
`default_nettype none

module fir_sample_ring (
  input  logic                                 clock,
  input  logic                                 rst,
  input  logic                                 write,
  input  logic signed [fir_pkg::sample_bits-1:0] in_data,
  input  logic        [fir_pkg::tap_bits-1:0]    tap_index,
  output logic signed [fir_pkg::sample_bits-1:0] sample
);

  import fir_pkg::*;

  logic signed [sample_bits-1:0] hist [num_taps];
  logic        [tap_bits-1:0]    wr_ptr;   // next slot to fill
  logic        [tap_bits-1:0]    rd_addr;

  // --------------------------------------------------
  // write side
  // --------------------------------------------------
  always_ff @(posedge clock)
  begin
    if (rst)
    begin
      wr_ptr <= '0;
      for (int i = 0; i < num_taps; i++)
        hist[i] <= '0;  // history before reset reads as zero
    end
    else if (write)
    begin
      hist[wr_ptr] <= in_data;
      wr_ptr       <= wr_ptr + 1'b1;  // wraps at num_taps
    end
  end

  // --------------------------------------------------
  // read side
  // --------------------------------------------------
  // newest sample sits one behind the write pointer
  assign rd_addr = wr_ptr - tap_bits'(1) - tap_index;

  always_ff @(posedge clock)
  begin
    sample <= hist[rd_addr];  // one cycle read latency
  end

  // the sequencer leaves at least one cycle between writes
  a_single_write: assert property (@(posedge clock) disable iff (rst)
    write |=> !write);

endmodule

`default_nettype wire

/* fir_sequencer.sv */
/*
  fir control sequencer
  accepts start, walks load / accumulate / drain / round,
  steps the tap index and decodes the state into MAC opcodes
*/
`default_nettype none

module fir_sequencer (
  input  logic                           clock,
  input  logic                           rst,
  input  logic                           start,
  output logic                           busy,
  output logic                           ring_write,
  output logic [fir_pkg::tap_bits-1:0]   tap_index,
  output fir_pkg::mac_op_t               mac_op,
  output logic                           round_go
);

  import fir_pkg::*;

  seq_state_t          state;
  logic [tap_bits-1:0] tap_count;    // tap being fetched
  logic [2:0]          drain_count;  // counts mac_latency+1 cycles

  // --------------------------------------------------
  // state machine
  // --------------------------------------------------
  always_ff @(posedge clock)
  begin
    if (rst)
    begin
      state       <= seq_idle;
      tap_count   <= '0;
      drain_count <= '0;
    end
    else
    begin
      case (state)
        seq_idle:
        begin
          if (start)
            state <= seq_load;  // sample is written on this edge
        end

        seq_load:
        begin
          tap_count <= '0;
          state     <= seq_accumulate;
        end

        seq_accumulate:
        begin
          tap_count <= tap_count + 1'b1;
          if (tap_count == tap_bits'(num_taps - 1))
          begin
            drain_count <= '0;
            state       <= seq_drain;
          end
        end

        seq_drain:
        begin
          drain_count <= drain_count + 1'b1;
          if (drain_count == 3'(mac_latency))  // 0..mac_latency inclusive
            state <= seq_round;
        end

        seq_round:
          state <= seq_idle;  // result is taken on this edge

        default:
          state <= seq_idle;
      endcase
    end
  end

  // --------------------------------------------------
  // opcode decode
  // --------------------------------------------------
  // registered one cycle so it meets the ring / ROM read data
  always_ff @(posedge clock)
  begin
    if (rst)
      mac_op <= mac_nop;
    else if (state == seq_accumulate)
    begin
      if (tap_count == '0)
        mac_op <= mac_first;  // tap 0 reloads the accumulator
      else
        mac_op <= mac_next;
    end
    else
      mac_op <= mac_nop;
  end

  assign busy       = (state != seq_idle);
  assign ring_write = (state == seq_idle) && start;  // starts while busy are dropped
  assign tap_index  = tap_count;
  assign round_go   = (state == seq_round);

  // round only ever follows a full drain
  a_round_after_drain: assert property (@(posedge clock) disable iff (rst)
    round_go |-> ($past(state) == seq_drain) && ($past(drain_count) == 3'(mac_latency)));

  // a write is only taken from idle and always makes the engine busy
  a_write_not_busy: assert property (@(posedge clock) disable iff (rst)
    ring_write |-> !busy ##1 busy);

endmodule

`default_nettype wire

/* fir_coeff_rom.sv */
/*
  fir coefficient ROM
  num_taps signed coefficients loaded from coeff.hex at
  elaboration, one registered read per cycle
*/
`default_nettype none

module fir_coeff_rom (
  input  logic                                 clock,
  input  logic        [fir_pkg::tap_bits-1:0]    tap_index,
  output logic signed [fir_pkg::sample_bits-1:0] coeff
);

  import fir_pkg::*;

  // one word per tap, tap 0 multiplies the newest sample
  logic signed [sample_bits-1:0] rom [num_taps];

  initial
  begin
    $readmemh("coeff.hex", rom);  // windowed low-pass
  end

  // registered read, same latency as the sample ring
  always_ff @(posedge clock)
  begin
    coeff <= rom[tap_index];
  end

endmodule

`default_nettype wire

/* fir_pkg.sv */
/*
  fir filter shared definitions
  tap count, datapath widths, sequencer states and the
  opcodes that the sequencer hands to the MAC pipeline
*/
`default_nettype none

package fir_pkg;

  // --------------------------------------------------
  // sizes
  // --------------------------------------------------
  localparam int num_taps    = 64;  // filter length
  localparam int tap_bits    = 6;   // log2(num_taps)
  localparam int sample_bits = 24;  // samples and coefficients
  localparam int acc_bits    = 56;  // MAC accumulator
  localparam int out_bits    = 32;  // rounded result
  localparam int mac_latency = 3;   // opcode in to acc_out

  // --------------------------------------------------
  // sequencer states
  // --------------------------------------------------
  typedef enum logic [2:0] {
    seq_idle,        // waiting for start
    seq_load,        // new sample lands in the ring
    seq_accumulate,  // one tap per cycle
    seq_drain,       // let the MAC pipeline empty
    seq_round        // hand the sum to the round stage
  } seq_state_t;

  // MAC opcodes, carried down the pipeline with the data
  typedef enum logic [1:0] {
    mac_nop,    // hold the accumulator
    mac_first,  // restart from this product
    mac_next    // add this product
  } mac_op_t;

endpackage

`default_nettype wire
